// ==== rtl/uart_bram_pkg.sv ====
// Shared definitions for the serial-line memory service.
// Holds the command opcodes, response codes, widths and the request structs
// passed from the command controller to the byte lanes and the serializer.

package uart_bram_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int BYTE_WIDTH   = 8;
    localparam int BYTE_NUM_DEF = 4;    // Lanes per memory word
    localparam int ADDR_WIDTH   = 8;    // One address byte covers all words

    //////////////////////////////////////////////////////////////////////
    // Command and response codes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        OP_WRITE = 8'h57,               // 'W'
        OP_READ  = 8'h52                // 'R'
    } opcode_e;

    typedef enum logic [7:0] {
        RSP_ACK = 8'h06,                // Write taken
        RSP_NAK = 8'h15                 // Unknown opcode
    } rsp_e;

    //////////////////////////////////////////////////////////////////////
    // Memory requests
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                               stb;
        logic [ADDR_WIDTH-1:0]              addr;
        logic [BYTE_NUM_DEF-1:0]            mask;
        logic [BYTE_NUM_DEF*BYTE_WIDTH-1:0] data;   // Lane 0 in the low byte
    } wr_req_t;

    typedef struct packed {
        logic                  stb;
        logic [ADDR_WIDTH-1:0] addr;
    } rd_req_t;

endpackage

// ==== rtl/uart_rx.sv ====
// Serial receiver, 8 data bits, one stop bit, no parity.
// The line is synchronised, each bit is sampled at mid-time, and a good
// frame ends with a one-cycle strobe in the middle of the stop bit.

`timescale 1ns/100ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       s_axis,
    input  logic       rst_n_i,
    input  logic       uart_rx_i,
    output logic       rx_valid_o,
    output logic [7:0] rx_byte_o
);

localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
localparam int HALF  = CLKS_PER_BIT / 2;

typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
} state_e;

state_e           state;
logic [2:0]       sync_q;       // Two sync flops plus one for edge detect
logic [CNT_W-1:0] clk_cnt;
logic [2:0]       bit_idx;
logic             line;
logic             bit_end;

assign line    = sync_q[1];
assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

always_ff @(posedge s_axis or negedge rst_n_i) begin
    if (!rst_n_i) begin
        sync_q     <= '1;
        state      <= RX_IDLE;
        clk_cnt    <= '0;
        bit_idx    <= '0;
        rx_valid_o <= 1'b0;
    end else begin
        sync_q     <= {sync_q[1:0], uart_rx_i};
        rx_valid_o <= 1'b0;
        clk_cnt    <= clk_cnt + 1'b1;
        case (state)
            RX_IDLE: begin
                clk_cnt <= '0;
                if (sync_q[2] && !line) state <= RX_START;   // Falling edge
            end
            RX_START: begin
                if (clk_cnt == CNT_W'(HALF - 1)) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= line ? RX_IDLE : RX_DATA;      // Glitch filter
                end
            end
            RX_DATA: begin
                if (bit_end) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
            end
            RX_STOP: begin
                if (bit_end) begin
                    rx_valid_o <= line;     // Bad stop bit drops the byte
                    state      <= RX_IDLE;
                end
            end
            default: state <= RX_IDLE;
        endcase
    end
end

// LSB arrives first, so shift in from the top
always_ff @(posedge s_axis) begin
    if (state == RX_DATA && bit_end) rx_byte_o <= {line, rx_byte_o[7:1]};
end

endmodule

// ==== rtl/uart_tx.sv ====
// Serial transmitter, one 10-bit frame per start strobe.
// Busy rises on the cycle after the strobe and falls at the end of the
// stop bit; the line rests high between frames.

`timescale 1ns/100ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       s_axis,
    input  logic       rst_n_i,
    input  logic       tx_start_i,
    input  logic [7:0] tx_byte_i,
    output logic       tx_busy_o,
    output logic       uart_tx_o
);

localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

logic [CNT_W-1:0] clk_cnt;
logic [3:0]       bit_cnt;      // 0 is the start bit, 9 the stop bit
logic [8:0]       shift_q;      // Data bits then the stop bit
logic             busy_q;
logic             line_q;
logic             bit_end;
logic             load;

assign bit_end   = busy_q && (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
assign load      = !busy_q && tx_start_i;
assign tx_busy_o = busy_q;
assign uart_tx_o = line_q;

always_ff @(posedge s_axis or negedge rst_n_i) begin
    if (!rst_n_i) begin
        busy_q  <= 1'b0;
        line_q  <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
    end else if (load) begin
        busy_q  <= 1'b1;
        line_q  <= 1'b0;        // Start bit
        clk_cnt <= '0;
        bit_cnt <= '0;
    end else if (bit_end) begin
        clk_cnt <= '0;
        if (bit_cnt == 4'd9) begin
            busy_q <= 1'b0;
        end else begin
            line_q  <= shift_q[0];
            bit_cnt <= bit_cnt + 4'd1;
        end
    end else if (busy_q) begin
        clk_cnt <= clk_cnt + 1'b1;
    end
end

always_ff @(posedge s_axis) begin
    if (load) begin
        shift_q <= {1'b1, tx_byte_i};
    end else if (bit_end) begin
        shift_q <= {1'b1, shift_q[8:1]};
    end
end

endmodule

// ==== rtl/cmd_ctrl.sv ====
// Command parser for the serial memory service.
// Takes received bytes as opcode, address, mask and data, then issues one
// write request, read request or status per command and holds until the
// response has been sent.

`timescale 1ns/100ps

module cmd_ctrl (
    input  logic                   s_axis,
    input  logic                   rst_n_i,
    input  logic                   rx_valid_i,
    input  logic [7:0]             rx_byte_i,
    input  logic                   rsp_done_i,
    output uart_bram_pkg::wr_req_t wr_req_o,
    output uart_bram_pkg::rd_req_t rd_req_o,
    output logic                   status_valid_o,
    output uart_bram_pkg::rsp_e    status_o
);

import uart_bram_pkg::*;

localparam int CNT_W = (BYTE_NUM_DEF > 1) ? $clog2(BYTE_NUM_DEF) : 1;
localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BYTE_NUM_DEF - 1);

typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_MASK,
    ST_DATA,
    ST_RESPOND
} state_e;

state_e                             state;
logic                               is_write;
logic [CNT_W-1:0]                   byte_cnt;
logic                               wr_stb;
logic                               rd_stb;
logic [ADDR_WIDTH-1:0]              addr_q;
logic [BYTE_NUM_DEF-1:0]            mask_q;
logic [BYTE_NUM_DEF*BYTE_WIDTH-1:0] data_q;

//////////////////////////////////////////////////////////////////////
// Parser FSM
//////////////////////////////////////////////////////////////////////

always_ff @(posedge s_axis or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state          <= ST_IDLE;
        is_write       <= 1'b0;
        byte_cnt       <= '0;
        wr_stb         <= 1'b0;
        rd_stb         <= 1'b0;
        status_valid_o <= 1'b0;
    end else begin
        wr_stb         <= 1'b0;
        rd_stb         <= 1'b0;
        status_valid_o <= 1'b0;
        case (state)
            ST_IDLE: begin
                if (rx_valid_i) begin
                    case (opcode_e'(rx_byte_i))
                        OP_WRITE: begin
                            is_write <= 1'b1;
                            state    <= ST_ADDR;
                        end
                        OP_READ: begin
                            is_write <= 1'b0;
                            state    <= ST_ADDR;
                        end
                        default: begin
                            status_valid_o <= 1'b1;     // NAK right away
                            state          <= ST_RESPOND;
                        end
                    endcase
                end
            end
            ST_ADDR: begin
                if (rx_valid_i) begin
                    if (is_write) begin
                        state <= ST_MASK;
                    end else begin
                        rd_stb <= 1'b1;
                        state  <= ST_RESPOND;
                    end
                end
            end
            ST_MASK: begin
                if (rx_valid_i) begin
                    byte_cnt <= '0;
                    state    <= ST_DATA;
                end
            end
            ST_DATA: begin
                if (rx_valid_i) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == LAST_BYTE) begin
                        wr_stb         <= 1'b1;
                        status_valid_o <= 1'b1;         // ACK with the write
                        state          <= ST_RESPOND;
                    end
                end
            end
            ST_RESPOND: begin
                if (rsp_done_i) state <= ST_IDLE;       // Bytes here are dropped
            end
            default: state <= ST_IDLE;
        endcase
    end
end

//////////////////////////////////////////////////////////////////////
// Command fields
//////////////////////////////////////////////////////////////////////

always_ff @(posedge s_axis) begin
    if (rx_valid_i) begin
        case (state)
            ST_IDLE: status_o <= RSP_NAK;
            ST_ADDR: addr_q <= rx_byte_i[ADDR_WIDTH-1:0];
            ST_MASK: mask_q <= rx_byte_i[BYTE_NUM_DEF-1:0];
            ST_DATA: begin
                data_q[byte_cnt*BYTE_WIDTH +: BYTE_WIDTH] <= rx_byte_i;
                status_o <= RSP_ACK;
            end
            default: ;
        endcase
    end
end

assign wr_req_o = '{stb: wr_stb, addr: addr_q, mask: mask_q, data: data_q};
assign rd_req_o = '{stb: rd_stb, addr: addr_q};

endmodule

// ==== rtl/byte_lane_ram.sv ====
// One byte lane of the word memory.
// Synchronous write and registered read on a shared address, shaped so
// synthesis maps it onto block RAM. One instance per byte of the word.

`timescale 1ns/100ps

module byte_lane_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                                s_axis,
    input  logic                                wr_en_i,
    input  logic [ADDR_WIDTH-1:0]               addr_i,
    input  logic [uart_bram_pkg::BYTE_WIDTH-1:0] wr_data_i,
    input  logic                                rd_en_i,
    output logic [uart_bram_pkg::BYTE_WIDTH-1:0] rd_data_o
);

localparam int DEPTH = 2 ** ADDR_WIDTH;

logic [uart_bram_pkg::BYTE_WIDTH-1:0] mem [DEPTH];

always_ff @(posedge s_axis) begin
    if (wr_en_i) begin
        mem[addr_i] <= wr_data_i;
    end
    if (rd_en_i) begin
        rd_data_o <= mem[addr_i];   // Valid the cycle after the read strobe
    end
end

endmodule

// ==== rtl/rsp_serializer.sv ====
// Response sender for the serial memory service.
// A status strobe sends its code as a single byte; a read strobe captures
// all lanes one cycle later and sends them least significant byte first.
// Done pulses when the last byte has left the transmitter.

`timescale 1ns/100ps

module rsp_serializer #(
    parameter int BYTE_NUM = uart_bram_pkg::BYTE_NUM_DEF
) (
    input  logic                                         s_axis,
    input  logic                                         rst_n_i,
    input  logic                                         status_valid_i,
    input  uart_bram_pkg::rsp_e                          status_i,
    input  logic                                         rd_strobe_i,
    input  logic [BYTE_NUM*uart_bram_pkg::BYTE_WIDTH-1:0] lane_data_i,
    input  logic                                         tx_busy_i,
    output logic                                         tx_start_o,
    output logic [7:0]                                   tx_byte_o,
    output logic                                         done_o
);

import uart_bram_pkg::*;

localparam int CNT_W = (BYTE_NUM > 1) ? $clog2(BYTE_NUM) : 1;

typedef enum logic [1:0] {
    SR_IDLE,
    SR_CAPTURE,     // Lane data valid in this cycle
    SR_SEND,
    SR_WAIT
} state_e;

state_e                         state;
logic [CNT_W-1:0]               left_q;     // Bytes still to send after this one
logic [BYTE_NUM*BYTE_WIDTH-1:0] shift_q;
logic                           byte_free;

assign byte_free = (state == SR_WAIT) && !tx_busy_i;

always_ff @(posedge s_axis or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state  <= SR_IDLE;
        left_q <= '0;
    end else begin
        case (state)
            SR_IDLE: begin
                if (status_valid_i) begin
                    left_q <= '0;
                    state  <= SR_WAIT;
                end else if (rd_strobe_i) begin
                    state <= SR_CAPTURE;
                end
            end
            SR_CAPTURE: begin
                left_q <= CNT_W'(BYTE_NUM - 1);
                state  <= SR_SEND;
            end
            SR_SEND: state <= SR_WAIT;      // Busy is up by the next cycle
            SR_WAIT: begin
                if (!tx_busy_i) begin
                    if (left_q == '0) begin
                        state <= SR_IDLE;
                    end else begin
                        left_q <= left_q - 1'b1;
                        state  <= SR_SEND;
                    end
                end
            end
            default: state <= SR_IDLE;
        endcase
    end
end

always_ff @(posedge s_axis) begin
    if (state == SR_CAPTURE) begin
        shift_q <= lane_data_i;
    end else if (byte_free && left_q != '0) begin
        shift_q <= shift_q >> BYTE_WIDTH;
    end
end

assign tx_start_o = (state == SR_IDLE && status_valid_i) || (state == SR_SEND);
assign tx_byte_o  = (state == SR_IDLE) ? status_i : shift_q[BYTE_WIDTH-1:0];
assign done_o     = byte_free && (left_q == '0);

endmodule

// ==== rtl/uart_bram_top.sv ====
// Top level of the serial memory service.
// Joins the receiver, command parser, byte-lane memory, response sender
// and transmitter. CLKS_PER_BIT sets the bit time; BYTE_NUM must match the
// lane count of the package request structs.

`timescale 1ns/100ps

module uart_bram_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int BYTE_NUM     = uart_bram_pkg::BYTE_NUM_DEF
) (
    input  logic s_axis,
    input  logic rst_n_i,
    input  logic uart_rx_i,
    output logic uart_tx_o
);

import uart_bram_pkg::*;

logic                           rx_valid;
logic [7:0]                     rx_byte;
wr_req_t                        wr_req;
rd_req_t                        rd_req;
logic                           status_valid;
rsp_e                           status;
logic                           rsp_done;
logic [ADDR_WIDTH-1:0]          lane_addr;
logic [BYTE_NUM*BYTE_WIDTH-1:0] lane_data;
logic                           tx_start;
logic [7:0]                     tx_byte;
logic                           tx_busy;

//////////////////////////////////////////////////////////////////////
// Command path
//////////////////////////////////////////////////////////////////////

uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .s_axis     (s_axis   ),
    .rst_n_i    (rst_n_i  ),
    .uart_rx_i  (uart_rx_i),
    .rx_valid_o (rx_valid ),
    .rx_byte_o  (rx_byte  )
);

cmd_ctrl u_cmd_ctrl (
    .s_axis         (s_axis      ),
    .rst_n_i        (rst_n_i     ),
    .rx_valid_i     (rx_valid    ),
    .rx_byte_i      (rx_byte     ),
    .rsp_done_i     (rsp_done    ),
    .wr_req_o       (wr_req      ),
    .rd_req_o       (rd_req      ),
    .status_valid_o (status_valid),
    .status_o       (status      )
);

//////////////////////////////////////////////////////////////////////
// Byte lanes
//////////////////////////////////////////////////////////////////////

assign lane_addr = rd_req.stb ? rd_req.addr : wr_req.addr;

for (genvar k = 0; k < BYTE_NUM; k++) begin : g_lane
    byte_lane_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_lane (
        .s_axis    (s_axis                                  ),
        .wr_en_i   (wr_req.stb && wr_req.mask[k]            ),
        .addr_i    (lane_addr                               ),
        .wr_data_i (wr_req.data[k*BYTE_WIDTH +: BYTE_WIDTH] ),
        .rd_en_i   (rd_req.stb                              ),
        .rd_data_o (lane_data[k*BYTE_WIDTH +: BYTE_WIDTH]   )
    );
end

//////////////////////////////////////////////////////////////////////
// Response path
//////////////////////////////////////////////////////////////////////

rsp_serializer #(.BYTE_NUM(BYTE_NUM)) u_rsp_serializer (
    .s_axis         (s_axis      ),
    .rst_n_i        (rst_n_i     ),
    .status_valid_i (status_valid),
    .status_i       (status      ),
    .rd_strobe_i    (rd_req.stb  ),
    .lane_data_i    (lane_data   ),
    .tx_busy_i      (tx_busy     ),
    .tx_start_o     (tx_start    ),
    .tx_byte_o      (tx_byte     ),
    .done_o         (rsp_done    )
);

uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .s_axis     (s_axis   ),
    .rst_n_i    (rst_n_i  ),
    .tx_start_i (tx_start ),
    .tx_byte_i  (tx_byte  ),
    .tx_busy_o  (tx_busy  ),
    .uart_tx_o  (uart_tx_o)
);

endmodule

// ==== bench/uart_bram_properties.sv ====
// Concurrent checks on the internal strobes and lines of the serial memory
// service. Bound into the top level by the testbench; fail_cnt holds the
// number of assertion failures seen so far.

`timescale 1ns/100ps

module uart_bram_properties (
    input logic                   s_axis,
    input logic                   rst_n_i,
    input uart_bram_pkg::wr_req_t wr_req_i,
    input uart_bram_pkg::rd_req_t rd_req_i,
    input logic                   status_valid_i,
    input logic                   rsp_done_i,
    input logic                   tx_busy_i,
    input logic                   uart_tx_i
);

int   fail_cnt = 0;
logic req;
logic pending;      // A response is owed

assign req = status_valid_i || rd_req_i.stb;

always_ff @(posedge s_axis or negedge rst_n_i) begin
    if (!rst_n_i) begin
        pending <= 1'b0;
    end else if (req) begin
        pending <= 1'b1;
    end else if (rsp_done_i) begin
        pending <= 1'b0;
    end
end

//////////////////////////////////////////////////////////////////////
// Memory strobes
//////////////////////////////////////////////////////////////////////

wr_one_cycle: assert property (@(posedge s_axis) disable iff (!rst_n_i)
    wr_req_i.stb |=> !wr_req_i.stb)
    else begin
        fail_cnt++;
        $error("Write strobe held for more than one cycle");
    end

rd_one_cycle: assert property (@(posedge s_axis) disable iff (!rst_n_i)
    rd_req_i.stb |=> !rd_req_i.stb)
    else begin
        fail_cnt++;
        $error("Read strobe held for more than one cycle");
    end

wr_rd_apart: assert property (@(posedge s_axis) disable iff (!rst_n_i)
    !(wr_req_i.stb && rd_req_i.stb))
    else begin
        fail_cnt++;
        $error("Write and read strobes high together");
    end

//////////////////////////////////////////////////////////////////////
// Response line and done
//////////////////////////////////////////////////////////////////////

line_idle_high: assert property (@(posedge s_axis) disable iff (!rst_n_i)
    !tx_busy_i |-> uart_tx_i)
    else begin
        fail_cnt++;
        $error("Transmit line low while the transmitter is idle");
    end

req_after_done: assert property (@(posedge s_axis) disable iff (!rst_n_i)
    req |-> !pending)
    else begin
        fail_cnt++;
        $error("New request before the previous response finished");
    end

done_once: assert property (@(posedge s_axis) disable iff (!rst_n_i)
    rsp_done_i |-> pending)
    else begin
        fail_cnt++;
        $error("Done pulse without an open request");
    end

endmodule

// ==== bench/tb_uart_bram.sv ====
// Testbench for the serial memory service.
// Sends command frames on the receive line, decodes the response line in a
// monitor, keeps a per-lane reference memory and checks every response.

`timescale 1ns/100ps

module tb_uart_bram;

import uart_bram_pkg::*;

localparam int CLKS_PER_BIT = 8;
localparam int CLK_NS       = 40;
localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
localparam int RSP_TIMEOUT  = 6 * FRAME_CLKS;                   // Longest response plus slack
localparam int WATCHDOG_NS  = 80 * 11 * FRAME_CLKS * CLK_NS + 200_000;

logic        s_axis;
logic        rst_n_i;
logic        uart_rx_i;
logic        uart_tx_o;

logic [31:0] ref_mem [256];
logic [3:0]  known [256];      // Lanes written so far
logic [7:0]  rsp_q [$];
logic [7:0]  written_q [$];
int          seed;
int          errors = 0;
int          checks = 0;

initial begin
    s_axis = 1'b0;
    forever #(CLK_NS / 2) s_axis = ~s_axis;
end

uart_bram_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .BYTE_NUM     (BYTE_NUM_DEF)
) u_uart_bram_top (
    .s_axis    (s_axis   ),
    .rst_n_i   (rst_n_i  ),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
);

bind uart_bram_top uart_bram_properties u_props (
    .s_axis         (s_axis      ),
    .rst_n_i        (rst_n_i     ),
    .wr_req_i       (wr_req      ),
    .rd_req_i       (rd_req      ),
    .status_valid_i (status_valid),
    .rsp_done_i     (rsp_done    ),
    .tx_busy_i      (tx_busy     ),
    .uart_tx_i      (uart_tx_o   )
);

//////////////////////////////////////////////////////////////////////
// Serial host side
//////////////////////////////////////////////////////////////////////

task automatic send_frame(input logic [7:0] b, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
        @(negedge s_axis);
        uart_rx_i = frame[i];
        repeat (CLKS_PER_BIT - 1) @(negedge s_axis);
    end
    @(negedge s_axis);
    uart_rx_i = 1'b1;      // Back to idle after a bad stop bit
endtask

// Entered on the first falling edge that sees the start bit
task automatic decode_byte(output logic [7:0] b, output logic ok);
    repeat (CLKS_PER_BIT / 2) @(negedge s_axis);
    ok = (uart_tx_o == 1'b0);
    for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge s_axis);
        b[i] = uart_tx_o;
    end
    repeat (CLKS_PER_BIT) @(negedge s_axis);
    ok = ok && uart_tx_o;
endtask

initial begin : rsp_monitor
    logic [7:0] b;
    logic       ok;
    forever begin
        @(negedge s_axis);
        if (rst_n_i && uart_tx_o == 1'b0) begin
            decode_byte(b, ok);
            assert (ok) else begin
                errors++;
                $display("Response frame ending at %0t has a bad start or stop bit", $time);
            end
            rsp_q.push_back(b);
        end
    end
end

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

task automatic expect_rsp(input logic [31:0] exp, input logic [3:0] valid, input int n,
                          input string what);
    int         waited;
    logic [7:0] got;
    waited = 0;
    while (rsp_q.size() < n && waited < RSP_TIMEOUT) begin
        @(negedge s_axis);
        waited++;
    end
    assert (rsp_q.size() >= n) else begin
        errors++;
        $display("Only %0d of %0d %s response bytes arrived in %0d cycles",
                 rsp_q.size(), n, what, waited);
    end
    for (int i = 0; i < n; i++) begin
        if (rsp_q.size() > 0) begin
            got = rsp_q.pop_front();
            if (valid[i]) begin
                checks++;
                assert (got == exp[8*i +: 8]) else begin
                    errors++;
                    $display("FAILED at %0t: uart_tx_o %s byte %0d expected %h got %h",
                             $time, what, i, exp[8*i +: 8], got);
                end
            end
        end
    end
endtask

task automatic expect_silence(input int cycles, input string what);
    for (int i = 0; i < cycles; i++) begin
        @(negedge s_axis);
        checks++;
        assert (uart_tx_o == 1'b1) else begin
            errors++;
            $display("FAILED at %0t: uart_tx_o during %s expected 1 got %b",
                     $time, what, uart_tx_o);
        end
    end
    assert (rsp_q.size() == 0) else begin
        errors++;
        $display("A response byte arrived during %s", what);
    end
endtask

task automatic write_word(input logic [7:0] addr, input logic [3:0] mask,
                          input logic [31:0] data);
    send_frame(OP_WRITE, 1'b1);
    send_frame(addr, 1'b1);
    send_frame({4'h0, mask}, 1'b1);
    for (int k = 0; k < 4; k++) begin
        send_frame(data[8*k +: 8], 1'b1);
    end
    for (int k = 0; k < 4; k++) begin
        if (mask[k]) begin
            ref_mem[addr][8*k +: 8] = data[8*k +: 8];
        end
    end
    known[addr] = known[addr] | mask;
    expect_rsp({24'h0, RSP_ACK}, 4'b0001, 1, "write");
endtask

task automatic read_word(input logic [7:0] addr);
    send_frame(OP_READ, 1'b1);
    send_frame(addr, 1'b1);
    expect_rsp(ref_mem[addr], known[addr], 4, "read");
endtask

//////////////////////////////////////////////////////////////////////
// Test sequence
//////////////////////////////////////////////////////////////////////

initial begin : main
    logic [7:0]  addr;
    logic [3:0]  mask;
    logic [31:0] data;
    int          idx;
    int          prop_fails;
    seed      = 32'h4cefadfc;
    rst_n_i   = 1'b0;
    uart_rx_i = 1'b1;
    for (int a = 0; a < 256; a++) begin
        known[a] = 4'h0;
    end
    repeat (16) @(negedge s_axis);
    rst_n_i = 1'b1;

    expect_silence(2 * FRAME_CLKS, "idle after reset");

    write_word(8'h3c, 4'hf, 32'h8badf00d);
    read_word(8'h3c);
    write_word(8'h3c, 4'b0101, 32'h11223344);      // Lanes 0 and 2 only
    read_word(8'h3c);

    send_frame(8'h3f, 1'b1);
    expect_rsp({24'h0, RSP_NAK}, 4'b0001, 1, "invalid opcode");
    write_word(8'hc5, 4'hf, 32'h01234567);
    read_word(8'hc5);

    for (int i = 0; i < 60; i++) begin
        if (written_q.size() == 0 || ($random(seed) & 1)) begin
            addr = 8'($random(seed));
            mask = 4'($random(seed));
            data = $random(seed);
            write_word(addr, mask, data);
            written_q.push_back(addr);
        end else begin
            idx = $unsigned($random(seed)) % written_q.size();
            read_word(written_q[idx]);
        end
    end

    send_frame(8'h3f, 1'b0);                       // Taken, it would draw an instant NAK
    expect_silence(FRAME_CLKS, "frame with bad stop bit");
    read_word(8'hc5);

    repeat (FRAME_CLKS) @(negedge s_axis);
    prop_fails = u_uart_bram_top.u_props.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t with the test unfinished, checks: %0d, errors: %0d",
             $time, checks, errors);
    $display("Testbench failed");
    $finish;
end

endmodule

// ==== tb.f ====
rtl/uart_bram_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_ctrl.sv
rtl/byte_lane_ram.sv
rtl/rsp_serializer.sv
rtl/uart_bram_top.sv
bench/uart_bram_properties.sv
bench/tb_uart_bram.sv

// ==== Makefile ====
# Verilator build and run of the serial memory service testbench

SRCS := $(wildcard rtl/*.sv bench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_uart_bram
	@out="$$(./obj_dir/Vtb_uart_bram +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

obj_dir/Vtb_uart_bram: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_uart_bram -Mdir obj_dir -o Vtb_uart_bram

clean:
	rm -rf obj_dir
